/* list.f */
design/dac_pkg.sv
design/dac_bit_timer.sv
design/sample_fifo.sv
design/dac_frame_fsm.sv
design/dac_shifter.sv
design/dac_out_top.sv
testbench/tb_clock.sv
testbench/dac_checker.sv
testbench/tb_monitor.sv
testbench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f list.f -o tb_top_sim \
    > build.log 2>&1 \
    && ./obj_dir/tb_top_sim > sim.log 2>&1
grep -qx "Everything OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* testbench/tb_top.sv */
`timescale 1ns/1ns

module tb_top
    import dac_pkg::*;
;

    localparam int          LAST_PUSH_FRAME = 22;
    localparam int          TIMEOUT_CYCLES  = 40 * FRAME_CYCLES + 4520;
    localparam logic [31:0] LFSR_SEED       = 32'd79484;
    localparam logic [31:0] LFSR_TAPS       = 32'h80200003;

    logic    clk245760;
    logic    rst;
    sample_t data_i;
    logic    lrck_i;
    logic    ack_i;
    logic    dac_sck;
    logic    dac_lrck;
    logic    dac_sda;
    logic    underrun;
    logic    overflow;
    logic    run_done;
    int      value_errors;
    int      protocol_errors;
    int      slots_done;
    logic    final_done;
    int      cycles;

    // expected played frames, read by the monitor
    sample_t exp_left [0:63];
    sample_t exp_right [0:63];
    logic    exp_silent [0:63];
    int      exp_cnt;
    int      exp_drops;

    // model of the FIFO contents
    sample_t     mq_data [$];
    logic        mq_lrck [$];
    logic [31:0] lfsr;

    tb_clock u_clock (
        .clk245760 (clk245760),
        .rst       (rst)
    );

    dac_out_top u_dut (
        .clk245760  (clk245760),
        .rst        (rst),
        .data_i     (data_i),
        .lrck_i     (lrck_i),
        .ack_i      (ack_i),
        .dac_sck_o  (dac_sck),
        .dac_lrck_o (dac_lrck),
        .dac_sda_o  (dac_sda),
        .underrun_o (underrun),
        .overflow_o (overflow)
    );

    tb_monitor u_mon (
        .clk245760         (clk245760),
        .rst               (rst),
        .sck_i             (dac_sck),
        .lrck_i            (dac_lrck),
        .sda_i             (dac_sda),
        .underrun_i        (underrun),
        .overflow_i        (overflow),
        .run_done_i        (run_done),
        .value_errors_o    (value_errors),
        .protocol_errors_o (protocol_errors),
        .slots_done_o      (slots_done),
        .final_done_o      (final_done)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic draw_sample(output sample_t s);
        int i;
        begin
            s = '0;
            for (i = 0; i < SAMPLE_BITS; i++) begin
                s    = {s[SAMPLE_BITS-2:0], lfsr[0]};
                lfsr = lfsr_next(lfsr);
            end
        end
    endtask

    task automatic record_frame(input sample_t l, input sample_t r, input logic silent);
        exp_left[exp_cnt]   = l;
        exp_right[exp_cnt]  = r;
        exp_silent[exp_cnt] = silent;
        exp_cnt++;
    endtask

    // predicted fsm decision at the next frame start
    task automatic decide_frame();
        sample_t l;
        sample_t r;
        begin
            if (mq_data.size() >= 2 && !mq_lrck[0]) begin
                l = mq_data.pop_front();
                r = mq_data.pop_front();
                void'(mq_lrck.pop_front());
                void'(mq_lrck.pop_front());
                record_frame(l, r, 1'b0);
            end else begin
                if (mq_data.size() >= 1 && mq_lrck[0]) begin
                    void'(mq_data.pop_front());
                    void'(mq_lrck.pop_front());
                end
                record_frame('0, '0, 1'b1);
            end
        end
    endtask

    task automatic push_word(input logic ch, input sample_t s);
        @(posedge clk245760);
        data_i <= s;
        lrck_i <= ch;
        ack_i  <= 1'b1;
        if (mq_data.size() < FIFO_DEPTH) begin
            mq_data.push_back(s);
            mq_lrck.push_back(ch);
        end else begin
            exp_drops++;
        end
    endtask

    task automatic push_pair();
        sample_t s;
        begin
            draw_sample(s);
            push_word(1'b0, s);
            draw_sample(s);
            push_word(1'b1, s);
        end
    endtask

    task automatic end_push();
        @(posedge clk245760);
        ack_i <= 1'b0;
    endtask

    // wait for a right half well away from the fsm pops
    task automatic wait_right_half();
        logic prev;
        begin
            @(negedge clk245760);
            prev = dac_lrck;
            @(negedge clk245760);
            while (!(dac_lrck && !prev)) begin
                prev = dac_lrck;
                @(negedge clk245760);
            end
        end
    endtask

    always @(posedge clk245760) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: playback did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        sample_t s;
        int      f;
        int      k;
        int      assert_errors;
        data_i    = '0;
        lrck_i    = 1'b0;
        ack_i     = 1'b0;
        run_done  = 1'b0;
        cycles    = 0;
        exp_cnt   = 0;
        exp_drops = 0;
        lfsr      = LFSR_SEED;
        // first frame starts before any push
        record_frame('0, '0, 1'b1);
        for (f = 0; f <= LAST_PUSH_FRAME; f++) begin
            wait_right_half();
            case (f)
                0, 1, 7, 14, 15, 16, 17, 22: begin
                end
                8: begin
                    draw_sample(s);
                    push_word(1'b0, s);
                end
                9: begin
                    draw_sample(s);
                    push_word(1'b1, s);
                    push_pair();
                end
                10: begin
                    draw_sample(s);
                    push_word(1'b1, s);
                    push_pair();
                end
                13: begin
                    for (k = 0; k < 6; k++) begin
                        push_pair();
                    end
                end
                default: begin
                    push_pair();
                end
            endcase
            end_push();
            decide_frame();
        end
        while (slots_done < 2 * exp_cnt) begin
            @(negedge clk245760);
        end
        @(posedge clk245760);
        run_done <= 1'b1;
        while (!final_done) begin
            @(negedge clk245760);
        end
        assert_errors = u_dut.u_checker.assert_errors;
        $display("closing: %0d value errors, %0d protocol errors, %0d assertion errors",
                 value_errors, protocol_errors, assert_errors);
        if (value_errors == 0 && protocol_errors == 0 && assert_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* testbench/tb_monitor.sv */
`timescale 1ns/1ns

module tb_monitor
    import dac_pkg::*;
(
    input  logic clk245760,
    input  logic rst,
    input  logic sck_i,
    input  logic lrck_i,
    input  logic sda_i,
    input  logic underrun_i,
    input  logic overflow_i,
    input  logic run_done_i,
    output int   value_errors_o,
    output int   protocol_errors_o,
    output int   slots_done_o,
    output logic final_done_o
);

    int                   post_rst;
    int                   bit_cnt;
    int                   ovf_cnt;
    logic                 sck_q;
    logic                 lrck_q;
    logic                 slot_lrck;
    logic                 und_seen;
    logic [SLOT_BITS-1:0] word;

    // expected I2S slot with a zero bit, the sample msb first and zero pad
    function automatic logic [SLOT_BITS-1:0] slot_of(input sample_t s);
        return {1'b0, s, 7'b0000000};
    endfunction

    task automatic check_slot();
        int      idx;
        logic    chan;
        sample_t exp_s;
        begin
            idx  = slots_done_o / 2;
            chan = (slots_done_o % 2) == 1;
            if (slot_lrck != chan) begin
                $display("[ERROR] %0t slot %0d has word clock %0b", $time, slots_done_o,
                         slot_lrck);
                protocol_errors_o++;
            end
            if (idx < tb_top.exp_cnt) begin
                exp_s = chan ? tb_top.exp_right[idx] : tb_top.exp_left[idx];
                if (word !== slot_of(exp_s)) begin
                    $display("[ERROR] %0t frame %0d chan %0b got %h expected %h", $time,
                             idx, chan, word, slot_of(exp_s));
                    value_errors_o++;
                end
                if (!chan) begin
                    if (und_seen != tb_top.exp_silent[idx]) begin
                        $display("[ERROR] %0t frame %0d underrun %0b expected %0b", $time,
                                 idx, und_seen, tb_top.exp_silent[idx]);
                        value_errors_o++;
                    end
                    und_seen = 1'b0;
                end
            end
            slots_done_o++;
        end
    endtask

    initial begin
        value_errors_o    = 0;
        protocol_errors_o = 0;
        slots_done_o      = 0;
        final_done_o      = 1'b0;
        ovf_cnt           = 0;
        und_seen          = 1'b0;
    end

    always @(posedge clk245760) begin
        if (rst) begin
            post_rst = 0;
            bit_cnt  = 0;
            sck_q    = 1'b0;
            lrck_q   = 1'b0;
            word     = '0;
        end else begin
            // hold-off after reset
            if (post_rst < RST_DELAY_CYCLES) begin
                if (sck_i || lrck_i || sda_i || underrun_i || overflow_i) begin
                    $display("[ERROR] %0t DAC pins active during reset hold-off", $time);
                    protocol_errors_o++;
                end
                post_rst++;
            end
            if (underrun_i) begin
                und_seen = 1'b1;
            end
            if (overflow_i) begin
                ovf_cnt++;
            end
            if (lrck_i != lrck_q && bit_cnt != 0) begin
                $display("[ERROR] %0t word clock edge after %0d bits", $time, bit_cnt);
                protocol_errors_o++;
            end
            if (sck_i && !sck_q) begin
                if (bit_cnt == 0) begin
                    slot_lrck = lrck_i;
                end else if (lrck_i != slot_lrck) begin
                    $display("[ERROR] %0t word clock changed inside a slot", $time);
                    protocol_errors_o++;
                end
                word = {word[SLOT_BITS-2:0], sda_i};
                bit_cnt++;
                if (bit_cnt == SLOT_BITS) begin
                    check_slot();
                    bit_cnt = 0;
                end
            end
            sck_q  = sck_i;
            lrck_q = lrck_i;
            if (run_done_i && !final_done_o) begin
                if (ovf_cnt != tb_top.exp_drops) begin
                    $display("[ERROR] %0t %0d overflow pulses, expected %0d", $time,
                             ovf_cnt, tb_top.exp_drops);
                    value_errors_o++;
                end
                final_done_o = 1'b1;
            end
        end
    end

endmodule

/* testbench/dac_checker.sv */
`timescale 1ns/1ns

module dac_checker (
    input logic clk245760,
    input logic rst,
    input logic ready_i,
    input logic sck_i,
    input logic lrck_i,
    input logic underrun_i,
    input logic overflow_i
);

    int assert_errors = 0;

    // word clock moves with the falling bit clock
    lrck_on_sck_fall: assert property (
        @(posedge clk245760) disable iff (rst)
        $changed(lrck_i) |-> $fell(sck_i)
    ) else begin
        $error("word clock changed without a falling bit clock");
        assert_errors++;
    end

    // status pulses quiet while in reset
    quiet_in_reset: assert property (
        @(posedge clk245760)
        (rst && $past(rst)) |-> (!underrun_i && !overflow_i)
    ) else begin
        $error("underrun or overflow high during reset");
        assert_errors++;
    end

    // half period of 4 clocks
    sck_half_period: assert property (
        @(posedge clk245760) disable iff (rst || !ready_i)
        $changed(sck_i) |-> ##1 $stable(sck_i) ##1 $stable(sck_i)
            ##1 $stable(sck_i) ##1 $changed(sck_i)
    ) else begin
        $error("bit clock did not toggle every 4 cycles");
        assert_errors++;
    end

endmodule

bind dac_out_top dac_checker u_checker (
    .clk245760  (clk245760),
    .rst        (rst),
    .ready_i    (ready),
    .sck_i      (dac_sck_o),
    .lrck_i     (dac_lrck_o),
    .underrun_i (underrun_o),
    .overflow_i (overflow_o)
);

/* testbench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk245760,
    output logic rst
);

    localparam int HALF_PERIOD = 4;
    localparam int RST_CYCLES  = 4;

    initial begin
        clk245760 = 1'b0;
        forever begin
            #HALF_PERIOD clk245760 = ~clk245760;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk245760);
        rst <= 1'b0;
    end

endmodule

/* design/dac_out_top.sv */
`timescale 1ns/1ns

module dac_out_top
    import dac_pkg::*;
(
    input  logic    clk245760,
    input  logic    rst,
    input  sample_t data_i,
    input  logic    lrck_i,
    input  logic    ack_i,
    output logic    dac_sck_o,
    output logic    dac_lrck_o,
    output logic    dac_sda_o,
    output logic    underrun_o,
    output logic    overflow_o
);

    logic    ready;
    logic    frame;
    logic    shift;
    logic    load;
    logic    chan;
    sample_t head_data;
    logic    head_lrck;
    level_t  level;
    logic    pop;
    sample_t left;
    sample_t right;

    dac_bit_timer u_timer (
        .clk245760 (clk245760),
        .rst       (rst),
        .ready_o   (ready),
        .frame_o   (frame),
        .shift_o   (shift),
        .load_o    (load),
        .chan_o    (chan),
        .bck_o     (dac_sck_o),
        .lrck_o    (dac_lrck_o)
    );

    sample_fifo u_fifo (
        .clk245760   (clk245760),
        .rst         (rst),
        .data_i      (data_i),
        .lrck_i      (lrck_i),
        .ack_i       (ack_i),
        .pop_i       (pop),
        .head_data_o (head_data),
        .head_lrck_o (head_lrck),
        .empty_o     (),
        .level_o     (level),
        .overflow_o  (overflow_o)
    );

    dac_frame_fsm u_fsm (
        .clk245760   (clk245760),
        .rst         (rst),
        .ready_i     (ready),
        .frame_i     (frame),
        .head_data_i (head_data),
        .head_lrck_i (head_lrck),
        .level_i     (level),
        .pop_o       (pop),
        .left_o      (left),
        .right_o     (right),
        .underrun_o  (underrun_o)
    );

    dac_shifter u_shifter (
        .clk245760 (clk245760),
        .rst       (rst),
        .shift_i   (shift),
        .load_i    (load),
        .chan_i    (chan),
        .left_i    (left),
        .right_i   (right),
        .sda_o     (dac_sda_o)
    );

endmodule

/* design/dac_shifter.sv */
`timescale 1ns/1ns

module dac_shifter
    import dac_pkg::*;
(
    input  logic    clk245760,
    input  logic    rst,
    input  logic    shift_i,
    input  logic    load_i,
    input  logic    chan_i,
    input  sample_t left_i,
    input  sample_t right_i,
    output logic    sda_o
);

    localparam int PAD_BITS = SLOT_BITS - SAMPLE_BITS;

    logic [SLOT_BITS-1:0] shreg;
    sample_t              sel_sample;

    // right while the word clock is high
    assign sel_sample = chan_i ? right_i : left_i;

    // load at the end of slot 0 so the msb lands in slot 1
    always_ff @(posedge clk245760) begin
        if (rst) begin
            shreg <= '0;
        end else if (load_i) begin
            shreg <= {sel_sample, {PAD_BITS{1'b0}}};
        end else if (shift_i) begin
            shreg <= {shreg[SLOT_BITS-2:0], 1'b0};
        end
    end

    assign sda_o = shreg[SLOT_BITS-1];

endmodule

/* design/dac_frame_fsm.sv */
`timescale 1ns/1ns

module dac_frame_fsm
    import dac_pkg::*;
(
    input  logic    clk245760,
    input  logic    rst,
    input  logic    ready_i,
    input  logic    frame_i,
    input  sample_t head_data_i,
    input  logic    head_lrck_i,
    input  level_t  level_i,
    output logic    pop_o,
    output sample_t left_o,
    output sample_t right_o,
    output logic    underrun_o
);

    frame_state_t state_q;
    frame_state_t state_d;
    logic         pair_ok;
    logic         silence;
    logic         underrun_q;
    sample_t      left_q;
    sample_t      right_q;

    // a left sample at the head with its partner behind it
    assign pair_ok = !head_lrck_i && (level_i >= level_t'(2));

    // frame played as silence with or without a discard
    assign silence = (state_q == WAIT_FRAME) && frame_i && !pair_ok;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            WAIT_READY: begin
                if (ready_i) begin
                    state_d = WAIT_FRAME;
                end
            end
            WAIT_FRAME: begin
                if (frame_i) begin
                    if (pair_ok) begin
                        state_d = POP_LEFT;
                    end else if (level_i != '0 && head_lrck_i) begin
                        // stray right sample
                        state_d = DISCARD;
                    end
                end
            end
            POP_LEFT: begin
                state_d = POP_RIGHT;
            end
            POP_RIGHT: begin
                state_d = WAIT_FRAME;
            end
            DISCARD: begin
                state_d = WAIT_FRAME;
            end
            default: begin
                state_d = WAIT_READY;
            end
        endcase
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            state_q <= WAIT_READY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            underrun_q <= 1'b0;
        end else begin
            underrun_q <= silence;
        end
    end

    // hold pair for the whole frame
    always_ff @(posedge clk245760) begin
        if (silence) begin
            left_q  <= '0;
            right_q <= '0;
        end else if (state_q == POP_LEFT) begin
            left_q <= head_data_i;
        end else if (state_q == POP_RIGHT) begin
            right_q <= head_data_i;
        end
    end

    assign pop_o = (state_q == POP_LEFT) || (state_q == POP_RIGHT) || (state_q == DISCARD);

    assign left_o     = left_q;
    assign right_o    = right_q;
    assign underrun_o = underrun_q;

endmodule

/* design/sample_fifo.sv */
`timescale 1ns/1ns

module sample_fifo
    import dac_pkg::*;
(
    input  logic    clk245760,
    input  logic    rst,
    input  sample_t data_i,
    input  logic    lrck_i,
    input  logic    ack_i,
    input  logic    pop_i,
    output sample_t head_data_o,
    output logic    head_lrck_o,
    output logic    empty_o,
    output level_t  level_o,
    output logic    overflow_o
);

    sample_t mem_data [FIFO_DEPTH];
    logic    mem_lrck [FIFO_DEPTH];
    ptr_t    wr_ptr;
    ptr_t    rd_ptr;
    level_t  level;
    logic    full;
    logic    do_push;
    logic    do_pop;
    logic    overflow_q;

    assign full    = (level == level_t'(FIFO_DEPTH));
    assign empty_o = (level == '0);
    assign do_push = ack_i && !full;
    assign do_pop  = pop_i && !empty_o;

    // sample storage
    always_ff @(posedge clk245760) begin
        if (do_push) begin
            mem_data[wr_ptr] <= data_i;
            mem_lrck[wr_ptr] <= lrck_i;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            level <= '0;
        end else begin
            unique case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // dropped push
    always_ff @(posedge clk245760) begin
        if (rst) begin
            overflow_q <= 1'b0;
        end else begin
            overflow_q <= ack_i && full;
        end
    end

    // first word fall through
    assign head_data_o = mem_data[rd_ptr];
    assign head_lrck_o = mem_lrck[rd_ptr];
    assign level_o     = level;
    assign overflow_o  = overflow_q;

endmodule

/* design/dac_bit_timer.sv */
`timescale 1ns/1ns

module dac_bit_timer
    import dac_pkg::*;
(
    input  logic clk245760,
    input  logic rst,
    output logic ready_o,
    output logic frame_o,
    output logic shift_o,
    output logic load_o,
    output logic chan_o,
    output logic bck_o,
    output logic lrck_o
);

    rst_cnt_t rst_cnt;
    phase_t   phase;
    logic     bit_end;
    logic     slot0;
    logic     bck_q;
    logic     chan_q;
    logic     frame_q;
    logic     shift_q;
    logic     load_q;

    // reset stretcher saturating at the hold-off count
    always_ff @(posedge clk245760) begin
        if (rst) begin
            rst_cnt <= '0;
        end else if (rst_cnt != rst_cnt_t'(RST_DELAY_CYCLES)) begin
            rst_cnt <= rst_cnt + 1'b1;
        end
    end

    assign ready_o = (rst_cnt == rst_cnt_t'(RST_DELAY_CYCLES));

    // frame phase held at zero until ready
    always_ff @(posedge clk245760) begin
        if (rst || !ready_o) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    assign bit_end = &phase[2:0];
    assign slot0   = (phase[7:3] == 5'd0);

    // outputs registered from the same phase so they stay aligned
    always_ff @(posedge clk245760) begin
        if (rst) begin
            bck_q   <= 1'b0;
            chan_q  <= 1'b0;
            frame_q <= 1'b0;
            shift_q <= 1'b0;
            load_q  <= 1'b0;
        end else begin
            bck_q   <= phase[2];
            chan_q  <= phase[$bits(phase_t)-1];
            frame_q <= ready_o && (phase == '0);
            shift_q <= ready_o && bit_end;
            load_q  <= ready_o && bit_end && slot0;
        end
    end

    assign bck_o   = bck_q;
    assign lrck_o  = chan_q;
    assign chan_o  = chan_q;
    assign frame_o = frame_q;
    assign shift_o = shift_q;
    assign load_o  = load_q;

endmodule

/* design/dac_pkg.sv */
package dac_pkg;

    // timing of the dac output path
    localparam int RST_DELAY_CYCLES = 31;
    localparam int FIFO_DEPTH       = 8;
    localparam int SLOT_BITS        = 32;
    localparam int SAMPLE_BITS      = 24;
    localparam int FRAME_CYCLES     = 512;

    typedef logic [SAMPLE_BITS-1:0] sample_t;

    // channel, bit slot, position within a bit
    typedef logic [$clog2(FRAME_CYCLES)-1:0] phase_t;

    typedef logic [$clog2(RST_DELAY_CYCLES+1)-1:0] rst_cnt_t;

    typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(FIFO_DEPTH):0] level_t;

    typedef enum logic [2:0] {
        WAIT_READY,
        WAIT_FRAME,
        POP_LEFT,
        POP_RIGHT,
        DISCARD
    } frame_state_t;

endpackage
